// ==== source/execPkg.sv ====
package execPkg;

  // ==========================================================
  // Widths
  // ==========================================================
  localparam int dataW  = 32;
  localparam int regW   = 4;
  localparam int shAmtW = 5;

  // ==========================================================
  // Operation encodings
  // ==========================================================
  // Result source of a bundle
  // Shift class bundles carry aluMov, so the ALU C is the shifter carry
  typedef enum logic [1:0] {
    opAlu   = 2'd0,
    opShift = 2'd1,
    opMult  = 2'd2
  } opClassT;

  // ARM data-processing opcodes, in instruction encoding order
  typedef enum logic [3:0] {
    aluAnd = 4'h0,
    aluEor = 4'h1,
    aluSub = 4'h2,
    aluRsb = 4'h3,
    aluAdd = 4'h4,
    aluAdc = 4'h5,
    aluSbc = 4'h6,
    aluRsc = 4'h7,
    aluTst = 4'h8,
    aluTeq = 4'h9,
    aluCmp = 4'ha,
    aluCmn = 4'hb,
    aluOrr = 4'hc,
    aluMov = 4'hd,
    aluBic = 4'he,
    aluMvn = 4'hf
  } aluOpT;

  // Shift type field, bits 6:5 of the instruction
  typedef enum logic [1:0] {
    shLsl = 2'd0,
    shLsr = 2'd1,
    shAsr = 2'd2,
    shRor = 2'd3
  } shiftT;

  typedef enum logic [1:0] {
    mulLo  = 2'd0,
    umulHi = 2'd1,
    smulHi = 2'd2
  } multOpT;

  // ==========================================================
  // Bundles
  // ==========================================================
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Decode output, registered into the execute stage
  typedef struct packed {
    logic              valid;
    opClassT           opClass;
    aluOpT             aluOp;
    shiftT             shiftType;
    multOpT            multOp;
    logic              shiftByReg;
    logic [shAmtW-1:0] shiftAmt;
    logic              useImm;
    logic [dataW-1:0]  imm;
    logic [regW-1:0]   srcA;
    logic [regW-1:0]   srcB;
    logic [regW-1:0]   dest;
    logic              writeReg;
    logic              setFlags;
    logic [dataW-1:0]  rdA;
    logic [dataW-1:0]  rdB;
  } decBundleT;

  // Execute output, registered into the memory stage
  typedef struct packed {
    logic             valid;
    logic [dataW-1:0] result;
    logic [dataW-1:0] storeData;
    logic [regW-1:0]  dest;
    logic             writeReg;
  } memBundleT;

endpackage

// ==== source/stageReg.sv ====
module stageReg #(
  parameter type payloadT = logic [31:0]
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    en,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  // ==========================================================
  // Pipeline register
  // ==========================================================
  // Flush loads an all zero bundle, so valid drops and a bubble enters
  // Enable low holds the current bundle for a stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (en) begin
      q <= d;
    end
  end

  // Hazard control must never flush a stage it is also stalling
  // Otherwise the held bundle would be lost
  property noFlushInStall;
    @(posedge clk) disable iff (!arstN)
      flush |-> en;
  endproperty

  flushStallCheck: assert property (noFlushInStall)
    else $error("stageReg flush asserted while stalled");

endmodule

// ==== source/operandBypass.sv ====
module operandBypass import execPkg::*; (
  input  decBundleT        exIn,
  input  memBundleT        memFwd,
  input  logic             wbValid,
  input  logic [regW-1:0]  wbDest,
  input  logic [dataW-1:0] wbResult,
  output logic [dataW-1:0] opA,
  output logic [dataW-1:0] opB,
  output logic [dataW-1:0] storeData
);

  // Forwarded B before the immediate mux
  logic [dataW-1:0] fwdB;

  // Hit flags per source, kept separate for waveform debug
  logic memHitA;
  logic memHitB;
  logic wbHitA;
  logic wbHitB;

  // ==========================================================
  // Forwarding comparisons
  // ==========================================================
  // Memory stage hit needs a valid bundle that writes a register
  assign memHitA = memFwd.valid && memFwd.writeReg && (memFwd.dest == exIn.srcA);
  assign memHitB = memFwd.valid && memFwd.writeReg && (memFwd.dest == exIn.srcB);

  // Writeback return path carries its own valid
  assign wbHitA = wbValid && (wbDest == exIn.srcA);
  assign wbHitB = wbValid && (wbDest == exIn.srcB);

  // Newest value wins, memory stage ahead of writeback
  function automatic logic [dataW-1:0] pickNewest(
    input logic             memHit,
    input logic             wbHit,
    input logic [dataW-1:0] memData,
    input logic [dataW-1:0] wbData,
    input logic [dataW-1:0] rfData
  );
    logic [dataW-1:0] sel;
    if (memHit) begin
      sel = memData;
    end else if (wbHit) begin
      sel = wbData;
    end else begin
      sel = rfData;
    end
    return sel;
  endfunction

  // ==========================================================
  // Operand selection
  // ==========================================================
  assign opA  = pickNewest(memHitA, wbHitA, memFwd.result, wbResult, exIn.rdA);
  assign fwdB = pickNewest(memHitB, wbHitB, memFwd.result, wbResult, exIn.rdB);

  // Immediate replaces operand B only
  assign opB = exIn.useImm ? exIn.imm : fwdB;

  // Store data is always the register value of srcB
  assign storeData = fwdB;

endmodule

// ==== source/shiftAlu.sv ====
module shiftAlu import execPkg::*; (
  input  logic [dataW-1:0]  opA,
  input  logic [dataW-1:0]  opB,
  input  aluOpT             aluOp,
  input  shiftT             shiftType,
  input  logic              shiftByReg,
  input  logic [shAmtW-1:0] shiftAmt,
  input  logic              carryIn,
  output logic [dataW-1:0]  aluResult,
  output flagsT             aluFlags,
  output logic [dataW-1:0]  shiftResult
);

  // Shift amount, a full byte when it comes from a register
  logic [7:0] amt;
  logic       amtBig;

  // Extended shifts, carry-out sits in the spare bit
  logic [dataW:0]        lslExt;
  logic [dataW:0]        lsrExt;
  logic signed [dataW:0] asrExt;
  logic [2*dataW-1:0]    rorExt;
  logic                  shiftCarry;

  // Adder operands after inversion for the subtract forms
  logic [dataW-1:0] addA;
  logic [dataW-1:0] addB;
  logic             addCin;
  logic [dataW:0]   sum;
  logic             isArith;
  logic [dataW-1:0] logicRes;

  // ==========================================================
  // Barrel shifter
  // ==========================================================
  assign amt    = shiftByReg ? opA[7:0] : 8'(shiftAmt);
  assign amtBig = |amt[7:5];

  assign lslExt = {1'b0, opB} << amt[4:0];
  assign lsrExt = {opB, 1'b0} >> amt[4:0];
  assign asrExt = $signed({opB, 1'b0}) >>> amt[4:0];
  assign rorExt = {opB, opB} >> amt[4:0];

  always_comb begin
    // Zero amount passes value and carry through
    shiftResult = opB;
    shiftCarry  = carryIn;
    if (amt != 8'd0) begin
      case (shiftType)
        shLsl: begin
          shiftResult = amtBig ? '0 : lslExt[dataW-1:0];
          shiftCarry  = amtBig ? ((amt == 8'd32) & opB[0]) : lslExt[dataW];
        end
        shLsr: begin
          shiftResult = amtBig ? '0 : lsrExt[dataW:1];
          shiftCarry  = amtBig ? ((amt == 8'd32) & opB[dataW-1]) : lsrExt[0];
        end
        shAsr: begin
          // Saturates to a sign fill
          shiftResult = amtBig ? {dataW{opB[dataW-1]}} : asrExt[dataW:1];
          shiftCarry  = amtBig ? opB[dataW-1] : asrExt[0];
        end
        default: begin
          // Rotate is modulo 32, carry is the new top bit
          shiftResult = rorExt[dataW-1:0];
          shiftCarry  = rorExt[dataW-1];
        end
      endcase
    end
  end

  // ==========================================================
  // ALU
  // ==========================================================
  always_comb begin
    addA    = opA;
    addB    = shiftResult;
    addCin  = 1'b0;
    isArith = 1'b1;
    case (aluOp)
      aluSub, aluCmp: begin
        addB   = ~shiftResult;
        addCin = 1'b1;
      end
      aluRsb: begin
        addA   = ~opA;
        addCin = 1'b1;
      end
      aluAdd, aluCmn: addCin = 1'b0;
      aluAdc: addCin = carryIn;
      aluSbc: begin
        addB   = ~shiftResult;
        addCin = carryIn;
      end
      aluRsc: begin
        addA   = ~opA;
        addCin = carryIn;
      end
      default: isArith = 1'b0;
    endcase
  end

  assign sum = {1'b0, addA} + {1'b0, addB} + {{dataW{1'b0}}, addCin};

  always_comb begin
    case (aluOp)
      aluAnd, aluTst: logicRes = opA & shiftResult;
      aluEor, aluTeq: logicRes = opA ^ shiftResult;
      aluOrr:         logicRes = opA | shiftResult;
      aluMov:         logicRes = shiftResult;
      aluBic:         logicRes = opA & ~shiftResult;
      aluMvn:         logicRes = ~shiftResult;
      default:        logicRes = '0;
    endcase
  end

  assign aluResult = isArith ? sum[dataW-1:0] : logicRes;

  // Logical ops take C from the shifter, V is kept by the merger
  always_comb begin
    aluFlags.n = aluResult[dataW-1];
    aluFlags.z = (aluResult == '0);
    aluFlags.c = isArith ? sum[dataW] : shiftCarry;
    aluFlags.v = isArith & (addA[dataW-1] == addB[dataW-1])
                 & (sum[dataW-1] != addA[dataW-1]);
  end

endmodule

// ==== source/multUnit.sv ====
module multUnit import execPkg::*; (
  input  logic [dataW-1:0] opA,
  input  logic [dataW-1:0] opB,
  input  multOpT           multOp,
  output logic [dataW-1:0] multResult,
  output logic             multN,
  output logic             multZ
);

  // Sign extension only for the signed high word
  logic signExt;

  // Operands widened by one bit so a single signed multiplier serves both
  logic signed [dataW:0] extA;
  logic signed [dataW:0] extB;

  // Full 64-bit product
  logic signed [2*dataW-1:0] prod;

  // ==========================================================
  // Product
  // ==========================================================
  assign signExt = (multOp == smulHi);

  // Unsigned forms zero extend, which keeps the product non-negative
  assign extA = {signExt & opA[dataW-1], opA};
  assign extB = {signExt & opB[dataW-1], opB};

  // Low word is the same for signed and unsigned
  assign prod = extA * extB;

  // ==========================================================
  // Word select
  // ==========================================================
  // Signedness already lives in the product, so both high forms share one word
  always_comb begin
    case (multOp)
      umulHi, smulHi: multResult = prod[2*dataW-1:dataW];
      default:        multResult = prod[dataW-1:0];
    endcase
  end

  // Flags from the returned word only
  assign multN = multResult[dataW-1];
  assign multZ = (multResult == '0);

endmodule

// ==== source/resultMerge.sv ====
module resultMerge import execPkg::*; (
  input  logic             clk,
  input  logic             arstN,
  input  logic             en,
  input  decBundleT        exIn,
  input  logic [dataW-1:0] aluResult,
  input  flagsT            aluFlags,
  input  logic [dataW-1:0] shiftResult,
  input  logic [dataW-1:0] multResult,
  input  logic             multN,
  input  logic             multZ,
  input  logic [dataW-1:0] storeData,
  output memBundleT        memNext,
  output flagsT            flags
);

  flagsT            flagsNext;
  logic [dataW-1:0] result;
  logic             isLogic;
  logic             isCompare;

  assign isLogic   = exIn.aluOp inside {aluAnd, aluEor, aluTst, aluTeq,
                                        aluOrr, aluMov, aluBic, aluMvn};
  assign isCompare = (exIn.opClass == opAlu)
                     && (exIn.aluOp inside {aluTst, aluTeq, aluCmp, aluCmn});

  // ==========================================================
  // Result and flag select
  // ==========================================================
  always_comb begin
    result    = '0;
    flagsNext = flags;
    case (exIn.opClass)
      opAlu: begin
        result      = aluResult;
        flagsNext.n = aluFlags.n;
        flagsNext.z = aluFlags.z;
        flagsNext.c = aluFlags.c;
        // Logical ops leave V alone
        flagsNext.v = isLogic ? flags.v : aluFlags.v;
      end
      opShift: begin
        result      = shiftResult;
        flagsNext.n = shiftResult[dataW-1];
        flagsNext.z = (shiftResult == '0);
        flagsNext.c = aluFlags.c;
      end
      opMult: begin
        // C and V kept
        result      = multResult;
        flagsNext.n = multN;
        flagsNext.z = multZ;
      end
      default: result = '0;
    endcase
  end

  // Compares update flags only, no register write
  assign memNext = '{valid:     exIn.valid,
                     result:    result,
                     storeData: storeData,
                     dest:      exIn.dest,
                     writeReg:  exIn.writeReg & ~isCompare};

  // NZCV register, loads with the exMem edge
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else if (en && exIn.valid && exIn.setFlags) begin
      flags <= flagsNext;
    end
  end

  // Decode must hand over exactly one result source per live bundle
  legalClassCheck: assert property (@(posedge clk) disable iff (!arstN)
    (en && exIn.valid) |-> (exIn.opClass inside {opAlu, opShift, opMult}))
    else $error("resultMerge illegal opClass %0d", exIn.opClass);

endmodule

// ==== source/execTop.sv ====
module execTop import execPkg::*; (
  input  logic             clk,
  input  logic             arstN,
  input  decBundleT        decIn,
  input  logic             stall,
  input  logic             flush,
  input  logic             wbValid,
  input  logic [regW-1:0]  wbDest,
  input  logic [dataW-1:0] wbResult,
  output memBundleT        memOut,
  output flagsT            flags
);

  decBundleT        exIn;
  memBundleT        memNext;
  logic [dataW-1:0] opA;
  logic [dataW-1:0] opB;
  logic [dataW-1:0] storeData;
  logic [dataW-1:0] aluResult;
  logic [dataW-1:0] shiftResult;
  logic [dataW-1:0] multResult;
  flagsT            aluFlags;
  logic             multN;
  logic             multZ;

  // ==========================================================
  // Decode to execute register
  // ==========================================================
  stageReg #(.payloadT(decBundleT)) idEx (
    .clk, .arstN, .en(~stall), .flush, .d(decIn), .q(exIn)
  );

  // ==========================================================
  // Execute datapath
  // ==========================================================
  // Memory stage result fed back from the exMem register
  operandBypass bypass (
    .exIn, .memFwd(memOut), .wbValid, .wbDest, .wbResult,
    .opA, .opB, .storeData
  );

  // Carry into the shifter comes from the held flags
  shiftAlu alu (
    .opA, .opB, .aluOp(exIn.aluOp), .shiftType(exIn.shiftType),
    .shiftByReg(exIn.shiftByReg), .shiftAmt(exIn.shiftAmt),
    .carryIn(flags.c), .aluResult, .aluFlags, .shiftResult
  );

  multUnit mult (
    .opA, .opB, .multOp(exIn.multOp), .multResult, .multN, .multZ
  );

  resultMerge merge (
    .clk, .arstN, .en(~stall), .exIn, .aluResult, .aluFlags,
    .shiftResult, .multResult, .multN, .multZ, .storeData,
    .memNext, .flags
  );

  // Execute to memory register, never flushed
  stageReg #(.payloadT(memBundleT)) exMem (
    .clk, .arstN, .en(~stall), .flush(1'b0), .d(memNext), .q(memOut)
  );

endmodule

// ==== verif/execVectors.svh ====
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// One table row
// Expected fields hold memOut and flags after the edge that takes the row
typedef struct {
  int               test;
  decBundleT        dec;
  logic             stall;
  logic             flush;
  logic             wbValid;
  logic [regW-1:0]  wbDest;
  logic [dataW-1:0] wbResult;
  memBundleT        expMem;
  flagsT            expFlags;
} vecT;

vecT vecQ[$];

// Reference pipeline state, cleared like the stage after reset
decBundleT mEx    = '0;
memBundleT mMem   = '0;
flagsT     mFlags = '0;

// ============================================================
// Reference model
// ============================================================
// ARM barrel shifter giving {carry, value}
function automatic logic [dataW:0] refShift(input logic [dataW-1:0] val, input shiftT st,
    input logic [7:0] amt, input logic cin);
  logic [dataW-1:0] res;
  logic             c;
  int               k;
  k   = amt;
  res = val;
  c   = cin;
  if (k != 0) begin
    case (st)
      shLsl: begin
        if (k < 32) begin
          res = val << k;
          c   = val[32-k];
        end else begin
          res = '0;
          c   = (k == 32) && val[0];
        end
      end
      shLsr: begin
        if (k < 32) begin
          res = val >> k;
          c   = val[k-1];
        end else begin
          res = '0;
          c   = (k == 32) && val[31];
        end
      end
      shAsr: begin
        if (k < 32) begin
          res = $signed(val) >>> k;
          c   = val[k-1];
        end else begin
          res = {dataW{val[31]}};
          c   = val[31];
        end
      end
      default: begin
        // Rotate counts modulo 32 and C is the new sign bit
        k = k % 32;
        if (k != 0) res = (val >> k) | (val << (32 - k));
        c = res[31];
      end
    endcase
  end
  return {c, res};
endfunction

// Gives {c, v, result} for x + y + cIn or for x - y with cIn as not-borrow
function automatic logic [dataW+1:0] addSub(input logic [dataW-1:0] x,
    input logic [dataW-1:0] y, input logic cIn, input logic sub);
  logic [63:0] ux;
  logic [63:0] uy;
  longint      sr;
  logic        c;
  ux = {32'b0, x};
  uy = {32'b0, y};
  if (sub) begin
    sr = longint'($signed(x)) - longint'($signed(y)) - longint'(!cIn);
    c  = (ux >= uy + 64'(!cIn));
  end else begin
    sr = longint'($signed(x)) + longint'($signed(y)) + longint'(cIn);
    c  = (ux + uy + 64'(cIn)) > 64'hffff_ffff;
  end
  // V when the signed result leaves the 32-bit range
  return {c, sr != longint'($signed(sr[31:0])), sr[31:0]};
endfunction

// Data-processing result with the new NZCV in the top nibble
function automatic logic [dataW+3:0] refAlu(input aluOpT op, input logic [dataW-1:0] a,
    input logic [dataW-1:0] b, input logic shC, input flagsT fin);
  logic [dataW+1:0] cvr;
  logic [dataW-1:0] r;
  flagsT            f;
  f = fin;
  case (op)
    aluSub, aluCmp: cvr = addSub(a, b, 1'b1, 1'b1);
    aluRsb:         cvr = addSub(b, a, 1'b1, 1'b1);
    aluAdd, aluCmn: cvr = addSub(a, b, 1'b0, 1'b0);
    aluAdc:         cvr = addSub(a, b, fin.c, 1'b0);
    aluSbc:         cvr = addSub(a, b, fin.c, 1'b1);
    aluRsc:         cvr = addSub(b, a, fin.c, 1'b1);
    default:        cvr = '0;
  endcase
  case (op)
    aluAnd, aluTst: r = a & b;
    aluEor, aluTeq: r = a ^ b;
    aluOrr:         r = a | b;
    aluMov:         r = b;
    aluBic:         r = a & ~b;
    aluMvn:         r = ~b;
    default:        r = cvr[dataW-1:0];
  endcase
  // Logical ops take C from the shifter and keep V
  if (op inside {aluAnd, aluEor, aluTst, aluTeq, aluOrr, aluMov, aluBic, aluMvn}) begin
    f.c = shC;
  end else begin
    f.c = cvr[dataW+1];
    f.v = cvr[dataW];
  end
  f.n = r[31];
  f.z = (r == '0);
  return {f, r};
endfunction

function automatic logic [dataW-1:0] refMult(input multOpT op, input logic [dataW-1:0] a,
    input logic [dataW-1:0] b);
  logic [63:0]        up;
  logic signed [63:0] sp;
  up = {32'b0, a} * {32'b0, b};
  sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
  case (op)
    umulHi:  return up[63:32];
    smulHi:  return sp[63:32];
    default: return up[31:0];
  endcase
endfunction

// Newest copy of a source register with the memory stage first
function automatic logic [dataW-1:0] forwardValue(input logic [regW-1:0] src,
    input logic [dataW-1:0] rf, input vecT v);
  if (mMem.valid && mMem.writeReg && (mMem.dest == src)) return mMem.result;
  if (v.wbValid && (v.wbDest == src)) return v.wbResult;
  return rf;
endfunction

// Moves the reference pipeline across one rising edge
function automatic void stepModel(input vecT v);
  decBundleT        e;
  logic [dataW-1:0] a;
  logic [dataW-1:0] bReg;
  logic [dataW-1:0] b;
  logic [dataW:0]   sh;
  logic [dataW+3:0] fr;
  logic [dataW-1:0] r;
  flagsT            f;
  e = mEx;
  if (!v.stall) begin
    a    = forwardValue(e.srcA, e.rdA, v);
    bReg = forwardValue(e.srcB, e.rdB, v);
    b    = e.useImm ? e.imm : bReg;
    sh   = refShift(b, e.shiftType, e.shiftByReg ? a[7:0] : 8'(e.shiftAmt), mFlags.c);
    f    = mFlags;
    case (e.opClass)
      opShift: begin
        r   = sh[dataW-1:0];
        f.n = r[31];
        f.z = (r == '0);
        f.c = sh[dataW];
      end
      opMult: begin
        // C and V stay
        r   = refMult(e.multOp, a, b);
        f.n = r[31];
        f.z = (r == '0);
      end
      default: begin
        fr = refAlu(e.aluOp, a, sh[dataW-1:0], sh[dataW], mFlags);
        f  = fr[dataW+3:dataW];
        r  = fr[dataW-1:0];
      end
    endcase
    if (e.valid && e.setFlags) mFlags = f;
    mMem.valid     = e.valid;
    mMem.result    = r;
    mMem.storeData = bReg;
    mMem.dest      = e.dest;
    mMem.writeReg  = e.writeReg
                     && !(e.opClass == opAlu && e.aluOp inside {aluTst, aluTeq, aluCmp, aluCmn});
    mEx = v.flush ? '0 : v.dec;
  end
endfunction

// ============================================================
// Table building
// ============================================================
task automatic pushVec(input int test, input decBundleT d, input logic st, input logic fl,
    input logic wv, input logic [regW-1:0] wd, input logic [dataW-1:0] wr);
  vecT v;
  v.test     = test;
  v.dec      = d;
  v.stall    = st;
  v.flush    = fl;
  v.wbValid  = wv;
  v.wbDest   = wd;
  v.wbResult = wr;
  stepModel(v);
  v.expMem   = mMem;
  v.expFlags = mFlags;
  vecQ.push_back(v);
endtask

task automatic pushOp(input int test, input decBundleT d);
  pushVec(test, d, 1'b0, 1'b0, 1'b0, '0, '0);
endtask

task automatic pushBubble(input int test);
  pushOp(test, '0);
endtask

`endif

// ==== verif/execTb.sv ====
module execTb import execPkg::*; ();

  logic             clk;
  logic             arstN;
  decBundleT        decIn;
  logic             stall;
  logic             flush;
  logic             wbValid;
  logic [regW-1:0]  wbDest;
  logic [dataW-1:0] wbResult;
  memBundleT        memOut;
  flagsT            flags;

  logic [31:0] lfsrState   = 32'he8f7;
  int          cycles      = 0;
  int          limitCycles = 0;
  int          errTotal    = 0;
  int          checkTotal  = 0;
  int          testChecks[7];
  int          testErrs[7];
  string       testNames[7] = '{"reset", "alu ops", "shifts", "multiply", "forwarding",
                                "stall and flush", "flag gating"};

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] stepLfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = stepLfsr(lfsrState);
      r = {r[30:0], lfsrState[0]};
    end
    return r;
  endfunction

  `include "execVectors.svh"

  execTop u_dut (
    .clk, .arstN, .decIn, .stall, .flush, .wbValid, .wbDest, .wbResult, .memOut, .flags
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit scales with the table length
  initial begin
    wait (limitCycles > 0);
    while (cycles < limitCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with the vector loop unfinished", cycles);
    $display("Result: FAILED");
    $finish;
  end

  // Valid ALU bundle that sets flags, B from the immediate, r3 = op(r1, imm)
  function automatic decBundleT aluBundle(input aluOpT op, input logic [dataW-1:0] a,
      input logic [dataW-1:0] imm);
    decBundleT d;
    d          = '0;
    d.valid    = 1'b1;
    d.opClass  = opAlu;
    d.aluOp    = op;
    d.useImm   = 1'b1;
    d.imm      = imm;
    d.rdA      = a;
    d.srcA     = 4'd1;
    d.srcB     = 4'd2;
    d.dest     = 4'd3;
    d.writeReg = 1'b1;
    d.setFlags = 1'b1;
    return d;
  endfunction

  task automatic buildTable();
    decBundleT  d;
    logic [4:0] immAmt[3];
    logic [7:0] regAmt[3];
    immAmt = '{5'd0, 5'd1, 5'd31};
    regAmt = '{8'd0, 8'd32, 8'd40};
    for (int op = 0; op < 16; op++) begin
      pushOp(1, aluBundle(aluOpT'(op), randBits(32), randBits(32)));
    end
    pushBubble(1);
    pushBubble(1);
    // Shift class rides on MOV
    for (int st = 0; st < 4; st++) begin
      for (int k = 0; k < 3; k++) begin
        d           = aluBundle(aluMov, randBits(32), randBits(32));
        d.opClass   = opShift;
        d.shiftType = shiftT'(st);
        d.shiftAmt  = immAmt[k];
        pushOp(2, d);
        d.shiftByReg = 1'b1;
        d.rdA        = (randBits(24) << 8) | 32'(regAmt[k]);
        d.imm        = randBits(32);
        pushOp(2, d);
      end
      // Carry in from the last shift
      pushOp(2, aluBundle(aluAdc, randBits(32), randBits(32)));
      pushOp(2, aluBundle(aluSbc, randBits(32), randBits(32)));
    end
    pushBubble(2);
    pushBubble(2);
    // Sets C and V so the multiplies can show they keep them
    pushOp(3, aluBundle(aluCmp, 32'h8000_0000, 32'h0000_0001));
    for (int m = 0; m < 3; m++) begin
      d         = aluBundle(aluMov, randBits(32), randBits(32));
      d.opClass = opMult;
      d.multOp  = multOpT'(m);
      d.useImm  = 1'b0;
      d.rdB     = randBits(32);
      pushOp(3, d);
      d.rdA = d.rdA | 32'h8000_0000;
      d.rdB = d.rdB | 32'h8000_0000;
      pushOp(3, d);
      // Zero product
      d.rdA = '0;
      pushOp(3, d);
    end
    pushBubble(3);
    pushBubble(3);
    // Back to back with both sources from the memory stage
    d      = aluBundle(aluAdd, randBits(32), randBits(32));
    d.dest = 4'd5;
    pushOp(4, d);
    d        = aluBundle(aluAdd, randBits(32), randBits(32));
    d.srcA   = 4'd5;
    d.srcB   = 4'd5;
    d.useImm = 1'b0;
    pushOp(4, d);
    // Writeback only, present while the bundle executes
    d      = aluBundle(aluOrr, randBits(32), randBits(32));
    d.srcA = 4'd6;
    pushOp(4, d);
    pushVec(4, '0, 1'b0, 1'b0, 1'b1, 4'd6, randBits(32));
    // Both stages hold r7 and memory wins
    d      = aluBundle(aluAdd, randBits(32), randBits(32));
    d.dest = 4'd7;
    pushOp(4, d);
    d      = aluBundle(aluEor, randBits(32), randBits(32));
    d.srcA = 4'd7;
    d.srcB = 4'd7;
    pushOp(4, d);
    pushVec(4, '0, 1'b0, 1'b0, 1'b1, 4'd7, randBits(32));
    pushBubble(4);
    pushBubble(4);
    pushOp(5, aluBundle(aluAdd, randBits(32), randBits(32)));
    pushOp(5, aluBundle(aluRsb, randBits(32), randBits(32)));
    d = aluBundle(aluSub, randBits(32), randBits(32));
    pushVec(5, d, 1'b1, 1'b0, 1'b1, 4'd1, randBits(32));
    pushVec(5, d, 1'b1, 1'b0, 1'b0, '0, '0);
    pushOp(5, d);
    // Flushed bundle becomes a bubble
    pushVec(5, aluBundle(aluMvn, randBits(32), randBits(32)), 1'b0, 1'b1, 1'b0, '0, '0);
    pushOp(5, aluBundle(aluOrr, randBits(32), randBits(32)));
    pushBubble(5);
    pushBubble(5);
    // N set, then two rows that must not touch flags, then Z set
    pushOp(6, aluBundle(aluMov, 32'h0, 32'h8000_0000));
    d       = aluBundle(aluCmp, 32'h0, 32'h0);
    d.valid = 1'b0;
    pushOp(6, d);
    d          = aluBundle(aluMov, 32'h0, 32'h0);
    d.setFlags = 1'b0;
    pushOp(6, d);
    pushOp(6, aluBundle(aluMov, 32'h0, 32'h0));
    pushBubble(6);
    pushBubble(6);
  endtask

  // ============================================================
  // Drive and check
  // ============================================================
  task automatic applyRow(input vecT v);
    decIn    = v.dec;
    stall    = v.stall;
    flush    = v.flush;
    wbValid  = v.wbValid;
    wbDest   = v.wbDest;
    wbResult = v.wbResult;
  endtask

  task automatic compareField(input int test, input int row, input string name,
      input logic [dataW-1:0] expVal, input logic [dataW-1:0] actVal);
    if (actVal !== expVal) begin
      $display("error %s row %0d expected %h actual %h", name, row, expVal, actVal);
      testErrs[test]++;
      errTotal++;
    end
  endtask

  // Bubbles are checked on valid only
  task automatic checkRow(input int i);
    vecT v;
    v = vecQ[i];
    testChecks[v.test]++;
    checkTotal++;
    compareField(v.test, i, "memOut.valid", 32'(v.expMem.valid), 32'(memOut.valid));
    if (v.expMem.valid) begin
      compareField(v.test, i, "memOut.result", v.expMem.result, memOut.result);
      compareField(v.test, i, "memOut.storeData", v.expMem.storeData, memOut.storeData);
      compareField(v.test, i, "memOut.dest", 32'(v.expMem.dest), 32'(memOut.dest));
      compareField(v.test, i, "memOut.writeReg", 32'(v.expMem.writeReg),
                   32'(memOut.writeReg));
    end
    compareField(v.test, i, "flags", 32'(v.expFlags), 32'(flags));
  endtask

  task automatic reportTest(input int t);
    $display("test %0d %s  %0d checks  %0d errors", t, testNames[t], testChecks[t],
             testErrs[t]);
  endtask

  initial begin
    decIn    = '0;
    stall    = 1'b0;
    flush    = 1'b0;
    wbValid  = 1'b0;
    wbDest   = '0;
    wbResult = '0;
    arstN    = 1'b0;
    buildTable();
    limitCycles = 4 * (vecQ.size() + 6);
    repeat (4) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);
    testChecks[0]++;
    checkTotal++;
    compareField(0, -1, "memOut.valid", 32'h0, 32'(memOut.valid));
    compareField(0, -1, "flags", 32'h0, 32'(flags));
    reportTest(0);
    // Row i is driven at a falling edge and its result is seen one cycle later
    for (int i = 0; i < vecQ.size(); i++) begin
      applyRow(vecQ[i]);
      @(posedge clk);
      @(negedge clk);
      checkRow(i);
      if (i == vecQ.size() - 1 || vecQ[i+1].test != vecQ[i].test) reportTest(vecQ[i].test);
    end
    $display("%0d checks  %0d errors  %0d rows", checkTotal, errTotal, vecQ.size());
    if (errTotal == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== armExec.f ====
+incdir+verif
source/execPkg.sv
source/stageReg.sv
source/operandBypass.sv
source/shiftAlu.sv
source/multUnit.sv
source/resultMerge.sv
source/execTop.sv
verif/execTb.sv
